// ==== hdl/rv_defs.svh ====
// rv32i core constants: data width, register count, reset pc and nop word

`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// data and address width
`define RV_XLEN 32

// integer register file depth
`define RV_REG_COUNT 32

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// addi x0, x0, 0
`define RV_NOP 32'h0000_0013

`endif

// ==== hdl/rv_pkg.sv ====
// rv32i core types: opcode and alu encodings plus the pipeline register layouts
`default_nettype none

`include "rv_defs.svh"

package rv_pkg;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS_B                              // lui
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4                                  // jal link
    } wb_sel_e;

    typedef struct packed {
        logic                valid;
        logic [`RV_XLEN-1:0] pc;
        logic [`RV_XLEN-1:0] instr;
    } if_id_t;

    typedef struct packed {
        logic                valid;
        logic [`RV_XLEN-1:0] pc;
        logic                reg_wen;
        logic                mem_ren;
        logic                mem_wen;
        logic                branch;
        logic                jump;
        logic [2:0]          br_cond;           // funct3 of the branch
        alu_op_e             alu_op;
        logic                use_imm;
        wb_sel_e             wb_sel;
        logic [`RV_XLEN-1:0] rs1_val;
        logic [`RV_XLEN-1:0] rs2_val;
        logic [4:0]          rs1;
        logic [4:0]          rs2;
        logic [4:0]          rd;
        logic [`RV_XLEN-1:0] imm;
    } id_ex_t;

    typedef struct packed {
        logic                valid;
        logic [4:0]          rd;
        logic                reg_wen;
        logic                mem_ren;
        logic                mem_wen;
        wb_sel_e             wb_sel;
        logic [`RV_XLEN-1:0] alu_result;
        logic [`RV_XLEN-1:0] store_data;
        logic [`RV_XLEN-1:0] pc4;
    } ex_mem_t;

    typedef struct packed {
        logic                wen;
        logic [4:0]          rd;
        logic [`RV_XLEN-1:0] data;
    } wb_t;

    typedef struct packed {
        logic                taken;
        logic [`RV_XLEN-1:0] target;
    } redirect_t;

endpackage

`default_nettype wire

// ==== hdl/fetch_stage.sv ====
// fetch stage: program counter, instruction request and the IF/ID register
`default_nettype none
`timescale 1ns/1ps

`include "rv_defs.svh"

module fetch_stage (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       stall,
    input  wire rv_pkg::redirect_t    redirect,
    output logic [`RV_XLEN-1:0]       imem_addr,
    output logic                      imem_valid,
    input  wire  [`RV_XLEN-1:0]       imem_rdata,
    output rv_pkg::if_id_t            if_id
);

    logic [`RV_XLEN-1:0] pc_q;
    logic                active_q;            // set on the first edge out of reset

    assign imem_addr  = pc_q;
    assign imem_valid = active_q;

    // program counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active_q <= 1'b0;
            pc_q     <= `RV_RESET_PC;
        end else begin
            active_q <= 1'b1;
            if (redirect.taken) begin
                pc_q <= redirect.target;      // branch or jal from execute
            end else if (active_q && !stall) begin
                pc_q <= pc_q + `RV_XLEN'd4;
            end
        end
    end

    // IF/ID register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            if_id.valid <= 1'b0;
            if_id.pc    <= `RV_RESET_PC;
            if_id.instr <= `RV_NOP;
        end else if (redirect.taken) begin
            if_id.valid <= 1'b0;              // wrong-path slot
            if_id.instr <= `RV_NOP;
        end else if (!stall) begin
            if_id.valid <= imem_valid;
            if_id.pc    <= pc_q;
            if_id.instr <= imem_valid ? imem_rdata : `RV_NOP;
        end
    end

    // the target comes from execute, so this covers the whole redirect path
    assert property (@(posedge clk) disable iff (!rst_n)
        active_q |=> (pc_q[1:0] == 2'b00))
        else $error("fetch pc is not word aligned");

endmodule

`default_nettype wire

// ==== hdl/decode_stage.sv ====
// decode stage: register file, decoder, immediates, load-use stall and ID/EX register
`default_nettype none
`timescale 1ns/1ps

`include "rv_defs.svh"

module decode_stage (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire rv_pkg::if_id_t    if_id,
    input  wire rv_pkg::redirect_t redirect,
    input  wire rv_pkg::wb_t       wb,
    output logic                   stall,
    output rv_pkg::id_ex_t         id_ex
);

    logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];
    rv_pkg::opcode_e     opcode;
    rv_pkg::alu_op_e     base_op;
    rv_pkg::id_ex_t      dec;
    logic [2:0]          funct3;
    logic [4:0]          rs1;
    logic [4:0]          rs2;
    logic [4:0]          rd;
    logic [`RV_XLEN-1:0] rs1_val;
    logic [`RV_XLEN-1:0] rs2_val;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_s;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_j;
    logic [`RV_XLEN-1:0] imm_u;
    logic                uses_rs1;
    logic                uses_rs2;

    assign opcode = rv_pkg::opcode_e'(if_id.instr[6:0]);
    assign funct3 = if_id.instr[14:12];
    assign rs1    = if_id.instr[19:15];
    assign rs2    = if_id.instr[24:20];
    assign rd     = if_id.instr[11:7];

    // register file, x0 is never written
    always_ff @(posedge clk) begin
        if (wb.wen && wb.rd != 5'd0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // same-cycle write is visible to the read
    assign rs1_val = (rs1 == 5'd0) ? '0 : (wb.wen && wb.rd == rs1) ? wb.data : regs[rs1];
    assign rs2_val = (rs2 == 5'd0) ? '0 : (wb.wen && wb.rd == rs2) ? wb.data : regs[rs2];

    // immediate formats
    assign imm_i = {{20{if_id.instr[31]}}, if_id.instr[31:20]};
    assign imm_s = {{20{if_id.instr[31]}}, if_id.instr[31:25], if_id.instr[11:7]};
    assign imm_b = {{19{if_id.instr[31]}}, if_id.instr[31], if_id.instr[7],
                    if_id.instr[30:25], if_id.instr[11:8], 1'b0};
    assign imm_j = {{11{if_id.instr[31]}}, if_id.instr[31], if_id.instr[19:12],
                    if_id.instr[20], if_id.instr[30:21], 1'b0};
    assign imm_u = {if_id.instr[31:12], 12'd0};

    // funct3 to alu op, shared by register and immediate forms
    always_comb begin
        case (funct3)
            3'b001:  base_op = rv_pkg::ALU_SLL;
            3'b010:  base_op = rv_pkg::ALU_SLT;
            3'b100:  base_op = rv_pkg::ALU_XOR;
            3'b101:  base_op = rv_pkg::ALU_SRL;
            3'b110:  base_op = rv_pkg::ALU_OR;
            3'b111:  base_op = rv_pkg::ALU_AND;
            default: base_op = rv_pkg::ALU_ADD;
        endcase
    end

    always_comb begin
        dec         = '0;
        uses_rs1    = 1'b0;
        uses_rs2    = 1'b0;
        dec.pc      = if_id.pc;
        dec.rs1     = rs1;
        dec.rs2     = rs2;
        dec.rd      = rd;
        dec.rs1_val = rs1_val;
        dec.rs2_val = rs2_val;
        dec.br_cond = funct3;
        if (if_id.valid) begin
            dec.valid = 1'b1;
            case (opcode)
                rv_pkg::OPC_OP: begin
                    uses_rs1    = 1'b1;
                    uses_rs2    = 1'b1;
                    dec.reg_wen = 1'b1;
                    dec.alu_op  = (funct3 == 3'b000 && if_id.instr[30]) ? rv_pkg::ALU_SUB
                                                                        : base_op;
                end
                rv_pkg::OPC_OP_IMM: begin
                    uses_rs1    = 1'b1;
                    dec.reg_wen = 1'b1;
                    dec.use_imm = 1'b1;
                    dec.alu_op  = base_op;
                    dec.imm     = imm_i;
                end
                rv_pkg::OPC_LUI: begin
                    dec.reg_wen = 1'b1;
                    dec.use_imm = 1'b1;
                    dec.alu_op  = rv_pkg::ALU_PASS_B;
                    dec.imm     = imm_u;
                end
                rv_pkg::OPC_LOAD: begin
                    uses_rs1    = 1'b1;
                    dec.reg_wen = 1'b1;
                    dec.mem_ren = 1'b1;
                    dec.use_imm = 1'b1;
                    dec.wb_sel  = rv_pkg::WB_MEM;
                    dec.imm     = imm_i;
                end
                rv_pkg::OPC_STORE: begin
                    uses_rs1    = 1'b1;
                    uses_rs2    = 1'b1;
                    dec.mem_wen = 1'b1;
                    dec.use_imm = 1'b1;
                    dec.imm     = imm_s;
                end
                rv_pkg::OPC_BRANCH: begin
                    uses_rs1   = 1'b1;
                    uses_rs2   = 1'b1;
                    dec.branch = 1'b1;
                    dec.imm    = imm_b;
                end
                rv_pkg::OPC_JAL: begin
                    dec.jump    = 1'b1;
                    dec.reg_wen = 1'b1;
                    dec.wb_sel  = rv_pkg::WB_PC4;
                    dec.imm     = imm_j;
                end
                default: ;                    // unsupported word runs as a nop
            endcase
        end
    end

    // load in ID/EX feeding a source here
    assign stall = id_ex.valid && id_ex.mem_ren && (id_ex.rd != 5'd0) &&
                   ((uses_rs1 && rs1 == id_ex.rd) || (uses_rs2 && rs2 == id_ex.rd));

    // ID/EX register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex <= '0;
        end else if (redirect.taken || stall) begin
            id_ex <= '0;                      // bubble
        end else begin
            id_ex <= dec;
        end
    end

    // a write to x0 leaves every real register as it was
    for (genvar r = 1; r < `RV_REG_COUNT; r++) begin : g_x0_guard
        assert property (@(posedge clk) disable iff (!rst_n)
            (wb.wen && wb.rd == 5'd0) |=> (regs[r] === $past(regs[r])))
            else $error("write to x0 changed register x%0d", r);
    end

endmodule

`default_nettype wire

// ==== hdl/execute_stage.sv ====
// execute stage: operand forwarding, ALU, branch resolution and EX/MEM register
`default_nettype none
`timescale 1ns/1ps

`include "rv_defs.svh"

module execute_stage (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire rv_pkg::id_ex_t  id_ex,
    input  wire rv_pkg::wb_t     wb,
    output rv_pkg::redirect_t    redirect,
    output rv_pkg::ex_mem_t      ex_mem
);

    logic [`RV_XLEN-1:0] mem_fwd;
    logic [`RV_XLEN-1:0] op1;
    logic [`RV_XLEN-1:0] op2;
    logic [`RV_XLEN-1:0] alu_b;
    logic [`RV_XLEN-1:0] alu_res;
    logic [`RV_XLEN-1:0] pc4;
    logic                cond_true;

    // EX/MEM first, then writeback, then the decode read
    function automatic logic [`RV_XLEN-1:0] fwd_operand(input logic [4:0]          idx,
                                                        input logic [`RV_XLEN-1:0] rf_val);
        if (idx != 5'd0 && ex_mem.valid && ex_mem.reg_wen && !ex_mem.mem_ren &&
            ex_mem.rd == idx) begin
            return mem_fwd;                   // load data not ready yet
        end
        if (idx != 5'd0 && wb.wen && wb.rd == idx) begin
            return wb.data;
        end
        return rf_val;
    endfunction

    assign mem_fwd = (ex_mem.wb_sel == rv_pkg::WB_PC4) ? ex_mem.pc4 : ex_mem.alu_result;

    always_comb begin
        op1 = fwd_operand(id_ex.rs1, id_ex.rs1_val);
        op2 = fwd_operand(id_ex.rs2, id_ex.rs2_val);
    end

    assign alu_b = id_ex.use_imm ? id_ex.imm : op2;

    always_comb begin
        case (id_ex.alu_op)
            rv_pkg::ALU_ADD: alu_res = op1 + alu_b;
            rv_pkg::ALU_SUB: alu_res = op1 - alu_b;
            rv_pkg::ALU_AND: alu_res = op1 & alu_b;
            rv_pkg::ALU_OR:  alu_res = op1 | alu_b;
            rv_pkg::ALU_XOR: alu_res = op1 ^ alu_b;
            rv_pkg::ALU_SLT: alu_res = {31'd0, $signed(op1) < $signed(alu_b)};
            rv_pkg::ALU_SLL: alu_res = op1 << alu_b[4:0];
            rv_pkg::ALU_SRL: alu_res = op1 >> alu_b[4:0];
            default:         alu_res = alu_b;
        endcase
    end

    // beq, bne, blt
    always_comb begin
        case (id_ex.br_cond)
            3'b000:  cond_true = (op1 == op2);
            3'b001:  cond_true = (op1 != op2);
            3'b100:  cond_true = ($signed(op1) < $signed(op2));
            default: cond_true = 1'b0;
        endcase
    end

    assign pc4             = id_ex.pc + `RV_XLEN'd4;
    assign redirect.taken  = id_ex.valid && (id_ex.jump || (id_ex.branch && cond_true));
    assign redirect.target = id_ex.pc + id_ex.imm;

    // EX/MEM register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem <= '0;
        end else begin
            ex_mem.valid      <= id_ex.valid;
            ex_mem.rd         <= id_ex.rd;
            ex_mem.reg_wen    <= id_ex.reg_wen;
            ex_mem.mem_ren    <= id_ex.mem_ren;
            ex_mem.mem_wen    <= id_ex.mem_wen;
            ex_mem.wb_sel     <= id_ex.wb_sel;
            ex_mem.alu_result <= alu_res;
            ex_mem.store_data <= op2;         // forwarded rs2
            ex_mem.pc4        <= pc4;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        redirect.taken |-> (redirect.target[1:0] == 2'b00))
        else $error("taken redirect to a misaligned target");

endmodule

`default_nettype wire

// ==== hdl/mem_wb_stage.sv ====
// memory and writeback stage: data memory request, MEM/WB register and result select
`default_nettype none
`timescale 1ns/1ps

`include "rv_defs.svh"

module mem_wb_stage (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire rv_pkg::ex_mem_t ex_mem,
    output logic [`RV_XLEN-1:0]  dmem_addr,
    output logic [`RV_XLEN-1:0]  dmem_wdata,
    output logic                 dmem_valid,
    output logic                 dmem_wen,
    input  wire  [`RV_XLEN-1:0]  dmem_rdata,
    output rv_pkg::wb_t          wb
);

    logic [`RV_XLEN-1:0] result;

    // request straight from EX/MEM, data comes back this cycle
    assign dmem_valid = ex_mem.valid && (ex_mem.mem_ren || ex_mem.mem_wen);
    assign dmem_wen   = ex_mem.valid && ex_mem.mem_wen;
    assign dmem_addr  = ex_mem.alu_result;
    assign dmem_wdata = ex_mem.store_data;

    always_comb begin
        case (ex_mem.wb_sel)
            rv_pkg::WB_MEM: result = dmem_rdata;
            rv_pkg::WB_PC4: result = ex_mem.pc4;
            default:        result = ex_mem.alu_result;
        endcase
    end

    // MEM/WB register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb <= '0;
        end else begin
            wb.wen  <= ex_mem.valid && ex_mem.reg_wen;
            wb.rd   <= ex_mem.rd;
            wb.data <= result;
        end
    end

    // word-only accesses, low address bits stay zero
    assert property (@(posedge clk) disable iff (!rst_n)
        dmem_valid |-> (dmem_addr[1:0] == 2'b00))
        else $error("data memory access to a misaligned address");

endmodule

`default_nettype wire

// ==== hdl/rv_core.sv ====
// rv32i five-stage core top: fetch, decode, execute and memory/writeback stages
`default_nettype none
`timescale 1ns/1ps

`include "rv_defs.svh"

module rv_core (
    input  wire                 clk,
    input  wire                 rst_n,
    output logic [`RV_XLEN-1:0] imem_addr,
    input  wire  [`RV_XLEN-1:0] imem_rdata,
    output logic                imem_valid,
    output logic [`RV_XLEN-1:0] dmem_addr,
    input  wire  [`RV_XLEN-1:0] dmem_rdata,
    output logic [`RV_XLEN-1:0] dmem_wdata,
    output logic                dmem_valid,
    output logic                dmem_wen
);

    rv_pkg::if_id_t    if_id;
    rv_pkg::id_ex_t    id_ex;
    rv_pkg::ex_mem_t   ex_mem;
    rv_pkg::wb_t       wb;
    rv_pkg::redirect_t redirect;
    logic              stall;                 // load-use hold from decode

    fetch_stage fetch_stage_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (stall),
        .redirect   (redirect),
        .imem_addr  (imem_addr),
        .imem_valid (imem_valid),
        .imem_rdata (imem_rdata),
        .if_id      (if_id)
    );

    decode_stage decode_stage_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .if_id    (if_id),
        .redirect (redirect),
        .wb       (wb),
        .stall    (stall),
        .id_ex    (id_ex)
    );

    execute_stage execute_stage_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .id_ex    (id_ex),
        .wb       (wb),                       // writeback forwarding
        .redirect (redirect),
        .ex_mem   (ex_mem)
    );

    mem_wb_stage mem_wb_stage_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .ex_mem     (ex_mem),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_valid (dmem_valid),
        .dmem_wen   (dmem_wen),
        .dmem_rdata (dmem_rdata),
        .wb         (wb)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_rv_core.sv ====
// testbench for the rv32i core: memory models, store checker and per-test report
`default_nettype none
`timescale 1ns/1ps

`include "rv_defs.svh"

module tb_rv_core;

    logic                clk;
    logic                rst_n;
    logic [`RV_XLEN-1:0] imem_addr;
    logic [`RV_XLEN-1:0] imem_rdata;
    logic                imem_valid;
    logic [`RV_XLEN-1:0] dmem_addr;
    logic [`RV_XLEN-1:0] dmem_rdata;
    logic [`RV_XLEN-1:0] dmem_wdata;
    logic                dmem_valid;
    logic                dmem_wen;

    logic [31:0] imem [0:255];
    logic [31:0] dmem [0:1023];

    string       test_names [$];
    int          test_errs [$];
    bit          test_done [$];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    int          exp_test [$];

    int          checks;
    int          errors;
    int          passed;
    int          failed;
    int          run_cycles;
    bit          reset_fault;
    bit          load_ok;
    logic        st_pending;
    logic [31:0] st_addr;
    logic [31:0] st_data;

    rv_core rv_core_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .imem_valid (imem_valid),
        .dmem_addr  (dmem_addr),
        .dmem_rdata (dmem_rdata),
        .dmem_wdata (dmem_wdata),
        .dmem_valid (dmem_valid),
        .dmem_wen   (dmem_wen)
    );

    always #10 clk = ~clk;                   // 20 ns period

    // both memories answer in the same cycle
    assign imem_rdata = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem[dmem_addr[11:2]];

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual, input int test_idx);
        checks++;
        if (expected !== actual) begin
            errors++;
            if (test_idx >= 0) begin
                test_errs[test_idx]++;
            end
            $display("CHECK FAILED %s: expected %h, actual %h", what, expected, actual);
        end
    endtask

    task automatic report_test(input int idx);
        int errs;
        errs = test_errs[idx];
        if (test_names[idx] == "zero_reg_and_reset" && reset_fault) begin
            errs++;                           // memory request seen during reset
        end
        test_done[idx] = 1'b1;
        if (errs == 0) begin
            passed++;
            $display("test %s: pass", test_names[idx]);
        end else begin
            failed++;
            $display("test %s: fail (%0d errors)", test_names[idx], errs);
        end
    endtask

    task automatic take_store(input logic [31:0] addr, input logic [31:0] data);
        int          idx;
        logic [31:0] a;
        logic [31:0] d;
        if (exp_addr.size() == 0) begin
            errors++;
            $display("unexpected store of %h to address %h after the last expected store",
                     data, addr);
        end else begin
            idx = exp_test.pop_front();
            a   = exp_addr.pop_front();
            d   = exp_data.pop_front();
            check_value({test_names[idx], " store address"}, a, addr, idx);
            check_value({test_names[idx], " store data"}, d, data, idx);
            if (exp_test.size() == 0 || exp_test[0] != idx) begin
                report_test(idx);             // last store of this test
            end
        end
    endtask

    task automatic load_vectors(output bit ok);
        int          fd;
        int          n;
        int          k;
        bit          bad;
        string       line;
        string       name;
        logic [31:0] base;
        logic [31:0] w0;
        logic [31:0] w1;
        logic [31:0] w2;
        logic [31:0] w3;
        logic [31:0] a;
        logic [31:0] d;
        ok  = 1'b0;
        bad = 1'b0;
        fd  = $fopen("testbench/rv_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open the vector file testbench/rv_vectors.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line.getc(0) == "#") begin
                    continue;
                end
                if (line.getc(0) == "P") begin
                    n   = $sscanf(line, "P %h %h %h %h %h", base, w0, w1, w2, w3);
                    bad = bad || (n != 5);
                    k   = int'(base >> 2);
                    imem[k]     = w0;
                    imem[k + 1] = w1;
                    imem[k + 2] = w2;
                    imem[k + 3] = w3;
                end else if (line.getc(0) == "T") begin
                    n   = $sscanf(line, "T %s", name);
                    bad = bad || (n != 1);
                    test_names.push_back(name);
                    test_errs.push_back(0);
                    test_done.push_back(1'b0);
                end else if (line.getc(0) == "E" && test_names.size() > 0) begin
                    n   = $sscanf(line, "E %h %h", a, d);
                    bad = bad || (n != 2);
                    exp_addr.push_back(a);
                    exp_data.push_back(d);
                    exp_test.push_back(test_names.size() - 1);
                end
            end
            $fclose(fd);
            if (bad) begin
                $display("vector file has a malformed line");
            end
            ok = (!bad && test_names.size() > 0 && exp_addr.size() > 0);
            if (!ok) begin
                $display("vector file holds no usable tests");
            end
        end
    endtask

    // sample the request mid-cycle, commit it at the next rising edge
    always @(negedge clk) begin
        if (!rst_n && dmem_valid) begin
            reset_fault = 1'b1;
            errors++;
            $display("dmem_valid was high while reset was asserted");
        end
        if (!rst_n && imem_valid) begin
            reset_fault = 1'b1;
            errors++;
            $display("imem_valid was high while reset was asserted");
        end
        if (rst_n) begin
            run_cycles++;
        end
        if (run_cycles == 2 && !imem_valid) begin
            errors++;
            $display("imem_valid did not rise after reset was released");
        end
        st_pending = rst_n && dmem_valid && dmem_wen;
        st_addr    = dmem_addr;
        st_data    = dmem_wdata;
    end

    always @(posedge clk) begin
        if (st_pending) begin
            dmem[st_addr[11:2]] <= st_data;
            take_store(st_addr, st_data);
        end
    end

    initial begin
        int cycles;
        clk         = 1'b0;
        rst_n       = 1'b0;
        checks      = 0;
        errors      = 0;
        passed      = 0;
        failed      = 0;
        run_cycles  = 0;
        reset_fault = 1'b0;
        st_pending  = 1'b0;
        st_addr     = '0;
        st_data     = '0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = `RV_NOP;
        end
        for (int i = 0; i < 1024; i++) begin
            dmem[i] = ~(i << 2);              // address-dependent fill
        end
        load_vectors(load_ok);
        if (!load_ok) begin
            errors++;
        end
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        // all expected stores, in program order
        cycles = 0;
        while (load_ok && exp_addr.size() != 0 && cycles < 4000) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_addr.size() != 0) begin
            errors++;
            $display("timeout: %0d expected stores still missing after %0d cycles",
                     exp_addr.size(), cycles);
        end

        // a few more cycles to catch stray stores
        cycles = 0;
        while (cycles < 30) begin
            @(posedge clk);
            cycles++;
        end

        for (int i = 0; i < test_names.size(); i++) begin
            if (!test_done[i]) begin
                test_errs[i]++;
                report_test(i);
            end
        end
        $display("tests passed %0d, tests failed %0d, checks %0d, errors %0d",
                 passed, failed, checks, errors);
        if (errors == 0 && failed == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/rv_vectors.txt ====
# P <word address> <instr> <instr> <instr> <instr> : program words in hex, four per line
# T <name> starts a test, E <address> <data> is its next expected store, in order
P 00000000 00500093 00300113 002081B3 40118233
P 00000010 003222B3 00519333 002353B3 00F3C413
P 00000020 03046493 01C4F513 10A02023 10302223
P 00000030 10402423 10502623 10602823 10702A23
P 00000040 10802C23 10902E23 123455B7 67858593
P 00000050 12B02023 07A00613 18C02023 18002683
P 00000060 01168713 18E02223 00100793 00200813
P 00000070 FFF00893 01078663 20F02023 01079663
P 00000080 2F102823 2F102823 21002223 00F84663
P 00000090 20F02423 00F8C663 2F102823 2F102823
P 000000A0 00F78663 2F102823 2F102823 21102623
P 000000B0 00C0096F 2F102823 2F102823 29202023
P 000000C0 05500013 30002023 00000A33 31402223
P 000000D0 0000006F 00000013 00000013 00000013
# add, sub, slt, sll, srl, xori, ori, andi, lui chained through forwarding
T alu_chain
E 00000100 0000001C
E 00000104 00000008
E 00000108 00000003
E 0000010C 00000001
E 00000110 00000010
E 00000114 00000002
E 00000118 0000000D
E 0000011C 0000003D
E 00000120 12345678
# store, load back, use at once
T load_use
E 00000180 0000007A
E 00000184 0000008B
# taken slots hold stores to 0x2f0, which must never show up
T branches
E 00000200 00000001
E 00000204 00000002
E 00000208 00000001
E 0000020C FFFFFFFF
# jal at 0xb0 links 0xb4
T jal_link
E 00000280 000000B4
# x0 written with 0x55, then stored
T zero_reg_and_reset
E 00000300 00000000
E 00000304 00000000

// ==== list.f ====
+incdir+hdl
hdl/rv_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/mem_wb_stage.sv
hdl/rv_core.sv
testbench/tb_rv_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_rv_core -o tb_rv_core
./obj_dir/tb_rv_core > sim.log 2>&1 || true
cat sim.log
if grep -q "CHECKS FAILED" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "ALL CHECKS PASSED" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
